//--- hdl/lsuPkg.sv
// load/store unit package holding the shared widths, queue depth, access size codes and types
package lsuPkg;

	// store queue geometry
	localparam int STQ_DEPTH = 8;
	localparam int STQ_IDX_W = 3;

	// datapath widths
	localparam int DATA_W   = 32;
	localparam int ADDR_W   = 8;
	localparam int OFFSET_W = 2;

	// internal data memory, always hits
	localparam int MEM_WORDS = 64;

	// access size codes, a larger code covers more bytes
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	// queue index, wraps naturally at STQ_DEPTH
	typedef logic [STQ_IDX_W-1:0] stqIdx_t;

	// occupancy needs one extra bit to tell full from empty
	typedef logic [STQ_IDX_W:0] stqCount_t;

	// full byte address
	typedef logic [ADDR_W-1:0] byteAddr_t;

	// word part of an address, indexes the data memory
	typedef logic [ADDR_W-OFFSET_W-1:0] wordAddr_t;

	// one data word
	typedef logic [DATA_W-1:0] dataWord_t;

	// access size code
	typedef logic [1:0] accessSize_t;

	// byte lane enables of a word
	typedef logic [DATA_W/8-1:0] byteEn_t;

endpackage

//--- hdl/storeQueue.sv
// store queue with allocation, execute, commit, recover and the load forwarding search
`timescale 1ns/1ps

module storeQueue (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stAlloc_i,
	input  logic                 stExecValid_i,
	input  lsuPkg::stqIdx_t      stExecIdx_i,
	input  lsuPkg::byteAddr_t    stExecAddr_i,
	input  lsuPkg::dataWord_t    stExecData_i,
	input  lsuPkg::accessSize_t  stExecSize_i,
	input  logic                 stCommit_i,
	input  logic                 recover_i,
	input  logic                 ldValid_i,
	input  lsuPkg::byteAddr_t    ldAddr_i,
	input  lsuPkg::accessSize_t  ldSize_i,
	input  lsuPkg::stqIdx_t      ldLastSt_i,
	input  logic                 ldHasOlderSt_i,
	input  logic                 ldPredVio_i,
	output logic                 stqFull_o,
	output logic                 fwdHit_o,
	output lsuPkg::dataWord_t    fwdData_o,
	output logic                 partialMatch_o,
	output logic                 disambigStall_o,
	output logic                 commitValid_o,
	output lsuPkg::byteAddr_t    commitAddr_o,
	output lsuPkg::dataWord_t    commitData_o,
	output lsuPkg::accessSize_t  commitSize_o
);

	// entry payload
	lsuPkg::byteAddr_t   stqAddr [lsuPkg::STQ_DEPTH];
	lsuPkg::dataWord_t   stqData [lsuPkg::STQ_DEPTH];
	lsuPkg::accessSize_t stqSize [lsuPkg::STQ_DEPTH];

	// control state
	logic [lsuPkg::STQ_DEPTH-1:0] addrValid;
	lsuPkg::stqIdx_t              head;
	lsuPkg::stqIdx_t              tail;
	lsuPkg::stqCount_t            count;

	logic doAlloc;
	logic doCommit;

	// load search state
	logic                         lastStInRange;
	logic [lsuPkg::STQ_DEPTH-1:0] window;
	logic                         anyMatch;
	lsuPkg::stqIdx_t              hitIdx;

	assign stqFull_o = (count == lsuPkg::STQ_DEPTH);

	// allocation is dropped while full, recover overrides everything
	assign doAlloc  = stAlloc_i & ~stqFull_o & ~recover_i;
	assign doCommit = stCommit_i & ~recover_i;

	// head entry goes to the memory on commit
	assign commitValid_o = doCommit;
	assign commitAddr_o  = stqAddr[head];
	assign commitData_o  = stqData[head];
	assign commitSize_o  = stqSize[head];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			addrValid <= '0;
		end
		else if (recover_i)
		begin
			// drop every uncommitted store
			tail      <= head;
			count     <= '0;
			addrValid <= '0;
		end
		else
		begin
			if (doAlloc)
			begin
				tail <= tail + 1'b1;
			end
			if (doCommit)
			begin
				head            <= head + 1'b1;
				addrValid[head] <= 1'b0;
			end
			// net occupancy change
			case ({doAlloc, doCommit})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (stExecValid_i)
			begin
				addrValid[stExecIdx_i] <= 1'b1;
			end
		end
	end

	// payload written when the store executes
	always_ff @(posedge clk)
	begin
		if (stExecValid_i && !recover_i)
		begin
			stqAddr[stExecIdx_i] <= stExecAddr_i;
			stqData[stExecIdx_i] <= stExecData_i;
			stqSize[stExecIdx_i] <= stExecSize_i;
		end
	end

	// lastSt must point inside the occupied range
	// head == tail is empty when count is zero, otherwise full
	always_comb
	begin
		if (count == '0)
		begin
			lastStInRange = 1'b0;
		end
		else if (head < tail)
		begin
			lastStInRange = (ldLastSt_i >= head) && (ldLastSt_i < tail);
		end
		else
		begin
			lastStInRange = (ldLastSt_i < tail) || (ldLastSt_i >= head);
		end
	end

	// vulnerable window, head up to lastSt in circular order
	always_comb
	begin
		for (int i = 0; i < lsuPkg::STQ_DEPTH; i++)
		begin
			if (!(ldValid_i && ldHasOlderSt_i && lastStInRange))
			begin
				window[i] = 1'b0;
			end
			else if (head <= ldLastSt_i)
			begin
				window[i] = (lsuPkg::stqIdx_t'(i) >= head) && (lsuPkg::stqIdx_t'(i) <= ldLastSt_i);
			end
			else
			begin
				// window wraps past the top entry
				window[i] = (lsuPkg::stqIdx_t'(i) >= head) || (lsuPkg::stqIdx_t'(i) <= ldLastSt_i);
			end
		end
	end

	// scan oldest to youngest so the last word match is the youngest
	always_comb
	begin : fwdScan
		lsuPkg::stqIdx_t idx;

		anyMatch        = 1'b0;
		hitIdx          = '0;
		disambigStall_o = 1'b0;
		idx             = '0;
		for (int k = 0; k < lsuPkg::STQ_DEPTH; k++)
		begin
			idx = head + lsuPkg::stqIdx_t'(k);
			if (window[idx] && addrValid[idx] &&
			    (stqAddr[idx][lsuPkg::ADDR_W-1:lsuPkg::OFFSET_W] ==
			     ldAddr_i[lsuPkg::ADDR_W-1:lsuPkg::OFFSET_W]))
			begin
				anyMatch = 1'b1;
				hitIdx   = idx;
			end
			// unknown older address, stall only if predicted to violate
			if (ldPredVio_i && window[idx] && !addrValid[idx])
			begin
				disambigStall_o = 1'b1;
			end
		end
	end

	// forward only when the youngest match covers the load bytes
	assign fwdHit_o = anyMatch &&
		(stqAddr[hitIdx][lsuPkg::OFFSET_W-1:0] == ldAddr_i[lsuPkg::OFFSET_W-1:0]) &&
		(stqSize[hitIdx] >= ldSize_i);
	assign partialMatch_o = anyMatch & ~fwdHit_o;
	assign fwdData_o      = stqData[hitIdx];

endmodule

//--- hdl/dataMemory.sv
// word-organized data memory with byte-lane store writes and combinational load read
`timescale 1ns/1ps

module dataMemory (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wrEn_i,
	input  lsuPkg::byteAddr_t    wrAddr_i,
	input  lsuPkg::dataWord_t    wrData_i,
	input  lsuPkg::accessSize_t  wrSize_i,
	input  lsuPkg::byteAddr_t    rdAddr_i,
	output lsuPkg::dataWord_t    rdWord_o
);

	lsuPkg::dataWord_t mem [lsuPkg::MEM_WORDS];

	lsuPkg::wordAddr_t wrWord;
	lsuPkg::wordAddr_t rdWord;
	lsuPkg::byteEn_t   sizeEn;
	lsuPkg::byteEn_t   laneEn;
	lsuPkg::dataWord_t laneData;

	assign wrWord = wrAddr_i[lsuPkg::ADDR_W-1:lsuPkg::OFFSET_W];
	assign rdWord = rdAddr_i[lsuPkg::ADDR_W-1:lsuPkg::OFFSET_W];

	// lanes covered by the store before alignment
	always_comb
	begin
		case (wrSize_i)
			lsuPkg::SIZE_BYTE: sizeEn = 4'b0001;
			lsuPkg::SIZE_HALF: sizeEn = 4'b0011;
			default:           sizeEn = 4'b1111;
		endcase
	end

	// move the store's low bytes up to its byte offset
	assign laneEn   = sizeEn << wrAddr_i[lsuPkg::OFFSET_W-1:0];
	assign laneData = wrData_i << {wrAddr_i[lsuPkg::OFFSET_W-1:0], 3'b000};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int w = 0; w < lsuPkg::MEM_WORDS; w++)
			begin
				mem[w] <= '0;
			end
		end
		else if (wrEn_i)
		begin
			for (int b = 0; b < lsuPkg::DATA_W/8; b++)
			begin
				if (laneEn[b])
				begin
					mem[wrWord][8*b +: 8] <= laneData[8*b +: 8];
				end
			end
		end
	end

	// always hits, no read latency
	assign rdWord_o = mem[rdWord];

endmodule

//--- hdl/loadResultMerge.sv
// load result stage that picks forwarded or memory data, extends it and registers the outcome
`timescale 1ns/1ps

module loadResultMerge (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         ldValid_i,
	input  logic [lsuPkg::OFFSET_W-1:0]  ldOffset_i,
	input  lsuPkg::accessSize_t          ldSize_i,
	input  logic                         ldSign_i,
	input  logic                         fwdHit_i,
	input  lsuPkg::dataWord_t            fwdData_i,
	input  logic                         partialMatch_i,
	input  logic                         disambigStall_i,
	input  lsuPkg::dataWord_t            memWord_i,
	output logic                         ldDataValid_o,
	output lsuPkg::dataWord_t            ldData_o,
	output logic                         ldForwarded_o,
	output logic                         ldViolate_o,
	output logic                         ldStall_o
);

	lsuPkg::dataWord_t selData;
	lsuPkg::dataWord_t extData;
	logic              ldStall;
	logic              ldDone;

	assign ldStall = ldValid_i & disambigStall_i;
	assign ldDone  = ldValid_i & ~disambigStall_i;

	// forwarded data already sits in the low bytes
	// memory data is shifted down by the offset
	assign selData = fwdHit_i ? fwdData_i : (memWord_i >> {ldOffset_i, 3'b000});

	always_comb
	begin
		case (ldSize_i)
			lsuPkg::SIZE_BYTE:
			begin
				extData = {{(lsuPkg::DATA_W-8){ldSign_i & selData[7]}}, selData[7:0]};
			end
			lsuPkg::SIZE_HALF:
			begin
				extData = {{(lsuPkg::DATA_W-16){ldSign_i & selData[15]}}, selData[15:0]};
			end
			lsuPkg::SIZE_WORD:
			begin
				extData = selData;
			end
			default:
			begin
				extData = selData;
			end
		endcase
	end

	// one cycle from load sample to result
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ldDataValid_o <= 1'b0;
			ldData_o      <= '0;
			ldForwarded_o <= 1'b0;
			ldViolate_o   <= 1'b0;
			ldStall_o     <= 1'b0;
		end
		else
		begin
			ldDataValid_o <= ldDone;
			ldStall_o     <= ldStall;
			ldForwarded_o <= ldDone & fwdHit_i;
			// partial overlap reported only for loads that finish
			ldViolate_o   <= ldDone & partialMatch_i;
			ldData_o      <= ldDone ? extData : '0;
		end
	end

endmodule

//--- hdl/loadExecPath.sv
// load execution path top joining the store queue, data memory and result merge
`timescale 1ns/1ps

module loadExecPath (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stAlloc_i,
	input  logic                 stExecValid_i,
	input  lsuPkg::stqIdx_t      stExecIdx_i,
	input  lsuPkg::byteAddr_t    stExecAddr_i,
	input  lsuPkg::dataWord_t    stExecData_i,
	input  lsuPkg::accessSize_t  stExecSize_i,
	input  logic                 stCommit_i,
	input  logic                 recover_i,
	input  logic                 ldValid_i,
	input  lsuPkg::byteAddr_t    ldAddr_i,
	input  lsuPkg::accessSize_t  ldSize_i,
	input  logic                 ldSign_i,
	input  lsuPkg::stqIdx_t      ldLastSt_i,
	input  logic                 ldHasOlderSt_i,
	input  logic                 ldPredVio_i,
	output logic                 stqFull_o,
	output logic                 ldDataValid_o,
	output lsuPkg::dataWord_t    ldData_o,
	output logic                 ldForwarded_o,
	output logic                 ldViolate_o,
	output logic                 ldStall_o
);

	// queue to merge
	logic                fwdHit;
	lsuPkg::dataWord_t   fwdData;
	logic                partialMatch;
	logic                disambigStall;

	// queue to memory
	logic                commitValid;
	lsuPkg::byteAddr_t   commitAddr;
	lsuPkg::dataWord_t   commitData;
	lsuPkg::accessSize_t commitSize;

	// memory to merge
	lsuPkg::dataWord_t   memWord;

	storeQueue stq0 (
		.clk             (clk),
		.reset           (reset),
		.stAlloc_i       (stAlloc_i),
		.stExecValid_i   (stExecValid_i),
		.stExecIdx_i     (stExecIdx_i),
		.stExecAddr_i    (stExecAddr_i),
		.stExecData_i    (stExecData_i),
		.stExecSize_i    (stExecSize_i),
		.stCommit_i      (stCommit_i),
		.recover_i       (recover_i),
		.ldValid_i       (ldValid_i),
		.ldAddr_i        (ldAddr_i),
		.ldSize_i        (ldSize_i),
		.ldLastSt_i      (ldLastSt_i),
		.ldHasOlderSt_i  (ldHasOlderSt_i),
		.ldPredVio_i     (ldPredVio_i),
		.stqFull_o       (stqFull_o),
		.fwdHit_o        (fwdHit),
		.fwdData_o       (fwdData),
		.partialMatch_o  (partialMatch),
		.disambigStall_o (disambigStall),
		.commitValid_o   (commitValid),
		.commitAddr_o    (commitAddr),
		.commitData_o    (commitData),
		.commitSize_o    (commitSize)
	);

	// read in parallel with the queue search
	dataMemory dmem0 (
		.clk      (clk),
		.reset    (reset),
		.wrEn_i   (commitValid),
		.wrAddr_i (commitAddr),
		.wrData_i (commitData),
		.wrSize_i (commitSize),
		.rdAddr_i (ldAddr_i),
		.rdWord_o (memWord)
	);

	loadResultMerge merge0 (
		.clk             (clk),
		.reset           (reset),
		.ldValid_i       (ldValid_i),
		.ldOffset_i      (ldAddr_i[lsuPkg::OFFSET_W-1:0]),
		.ldSize_i        (ldSize_i),
		.ldSign_i        (ldSign_i),
		.fwdHit_i        (fwdHit),
		.fwdData_i       (fwdData),
		.partialMatch_i  (partialMatch),
		.disambigStall_i (disambigStall),
		.memWord_i       (memWord),
		.ldDataValid_o   (ldDataValid_o),
		.ldData_o        (ldData_o),
		.ldForwarded_o   (ldForwarded_o),
		.ldViolate_o     (ldViolate_o),
		.ldStall_o       (ldStall_o)
	);

endmodule

//--- tb/loadExecPath_chk.sv
// port-level protocol checker for the load execution path, attached by bind
`timescale 1ns/1ps

module loadExecPath_chk (
	input logic clk,
	input logic reset,
	input logic stAlloc_i,
	input logic stCommit_i,
	input logic recover_i,
	input logic stqFull_i,
	input logic ldDataValid_i,
	input logic ldForwarded_i,
	input logic ldStall_i
);

	// queue occupancy rebuilt from the ports
	lsuPkg::stqCount_t occ;

	// assertion failures so far
	int failCount = 0;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			occ <= '0;
		else if (recover_i)
			occ <= '0;
		else
			occ <= occ + (stAlloc_i && !stqFull_i) - stCommit_i;
	end

	// a load either finishes or stalls
	resultOrStall: assert property (@(posedge clk) disable iff (reset)
		!(ldDataValid_i && ldStall_i))
	else
	begin
		$error("load result valid and stall high together");
		failCount++;
	end

	forwardHasData: assert property (@(posedge clk) disable iff (reset)
		ldForwarded_i |-> ldDataValid_i)
	else
	begin
		$error("forwarded flag without a valid load result");
		failCount++;
	end

	// no retire from an empty queue
	commitNotEmpty: assert property (@(posedge clk) disable iff (reset)
		stCommit_i |-> (occ != '0))
	else
	begin
		$error("store commit while the queue is empty");
		failCount++;
	end

endmodule

bind loadExecPath loadExecPath_chk chk0 (
	.clk           (clk),
	.reset         (reset),
	.stAlloc_i     (stAlloc_i),
	.stCommit_i    (stCommit_i),
	.recover_i     (recover_i),
	.stqFull_i     (stqFull_o),
	.ldDataValid_i (ldDataValid_o),
	.ldForwarded_i (ldForwarded_o),
	.ldStall_i     (ldStall_o)
);

//--- tb/lsuRefModel.svh
// reference model of the store queue, data memory and load result for the load path testbench

// queue entries as the model sees them after each edge
lsuPkg::byteAddr_t            mAddr [lsuPkg::STQ_DEPTH];
lsuPkg::dataWord_t            mData [lsuPkg::STQ_DEPTH];
lsuPkg::accessSize_t          mSize [lsuPkg::STQ_DEPTH];
logic [lsuPkg::STQ_DEPTH-1:0] mKnown;
int                           mHead;
int                           mCount;

// memory image
lsuPkg::dataWord_t mMem [lsuPkg::MEM_WORDS];

// load outputs expected in the cycle after the load
logic              expValid;
lsuPkg::dataWord_t expData;
logic              expFwd;
logic              expVio;
logic              expStall;

task automatic resetModel();
	mHead  = 0;
	mCount = 0;
	mKnown = '0;
	for (int w = 0; w < lsuPkg::MEM_WORDS; w++)
		mMem[w] = '0;
	expValid = 1'b0;
	expData  = '0;
	expFwd   = 1'b0;
	expVio   = 1'b0;
	expStall = 1'b0;
endtask

// result of the load currently driven, from the state before the edge
task automatic predictLoad();
	int                span;
	int                idx;
	int                hit;
	int                nBytes;
	logic              match;
	logic              unknown;
	lsuPkg::wordAddr_t ldWord;
	lsuPkg::dataWord_t src;
	lsuPkg::dataWord_t mask;
	ldWord  = ldAddr[lsuPkg::ADDR_W-1:lsuPkg::OFFSET_W];
	span    = -1;
	match   = 1'b0;
	unknown = 1'b0;
	hit     = 0;
	// distance from the head to the last older store, in range only if occupied
	if (ldHasOlderSt && mCount > 0)
	begin
		idx = (int'(ldLastSt) - mHead + lsuPkg::STQ_DEPTH) % lsuPkg::STQ_DEPTH;
		if (idx < mCount)
			span = idx;
	end
	// oldest first, so a later match overrides an earlier one
	for (int k = 0; k <= span; k++)
	begin
		idx = (mHead + k) % lsuPkg::STQ_DEPTH;
		if (!mKnown[idx])
			unknown = 1'b1;
		else if (mAddr[idx][lsuPkg::ADDR_W-1:lsuPkg::OFFSET_W] == ldWord)
		begin
			match = 1'b1;
			hit   = idx;
		end
	end
	expStall = ldValid && ldPredVio && unknown;
	expValid = ldValid && !expStall;
	expFwd   = expValid && match &&
		(mAddr[hit][lsuPkg::OFFSET_W-1:0] == ldAddr[lsuPkg::OFFSET_W-1:0]) &&
		(mSize[hit] >= ldSize);
	expVio   = expValid && match && !expFwd;
	// keep the low bytes of the load size, then fill the top
	nBytes = 1 << ldSize;
	mask   = (nBytes == 4) ? '1 : ((32'd1 << (8 * nBytes)) - 32'd1);
	src    = expFwd ? mData[hit] : (mMem[ldWord] >> (8 * ldAddr[lsuPkg::OFFSET_W-1:0]));
	src    = src & mask;
	if (ldSign && src[8*nBytes-1])
		src = src | ~mask;
	expData = expValid ? src : '0;
endtask

// store side effects of one clock edge
task automatic applyStoreEdge();
	logic              wasFull;
	lsuPkg::wordAddr_t w;
	int                off;
	wasFull = (mCount == lsuPkg::STQ_DEPTH);
	if (recover)
	begin
		mCount = 0;
		mKnown = '0;
	end
	else
	begin
		if (stCommit)
		begin
			// head store lands in memory byte by byte
			w   = mAddr[mHead][lsuPkg::ADDR_W-1:lsuPkg::OFFSET_W];
			off = mAddr[mHead][lsuPkg::OFFSET_W-1:0];
			for (int b = 0; b < (1 << mSize[mHead]); b++)
				mMem[w][8*(off+b) +: 8] = mData[mHead][8*b +: 8];
			mKnown[mHead] = 1'b0;
			mHead  = (mHead + 1) % lsuPkg::STQ_DEPTH;
			mCount = mCount - 1;
		end
		if (stAlloc && !wasFull)
			mCount = mCount + 1;
		if (stExecValid)
		begin
			mKnown[stExecIdx] = 1'b1;
			mAddr[stExecIdx]  = stExecAddr;
			mData[stExecIdx]  = stExecData;
			mSize[stExecIdx]  = stExecSize;
		end
	end
endtask

//--- tb/loadExecPath_tb.sv
// testbench for the load execution path with random legal traffic checked against a model
`timescale 1ns/1ps

module loadExecPath_tb;

	localparam int NUM_OPS = 4000;

	logic clk;
	logic reset;

	// store side
	logic                stAlloc;
	logic                stExecValid;
	lsuPkg::stqIdx_t     stExecIdx;
	lsuPkg::byteAddr_t   stExecAddr;
	lsuPkg::dataWord_t   stExecData;
	lsuPkg::accessSize_t stExecSize;
	logic                stCommit;
	logic                recover;

	// load side
	logic                ldValid;
	lsuPkg::byteAddr_t   ldAddr;
	lsuPkg::accessSize_t ldSize;
	logic                ldSign;
	lsuPkg::stqIdx_t     ldLastSt;
	logic                ldHasOlderSt;
	logic                ldPredVio;

	// DUT outputs
	logic                stqFull;
	logic                ldDataValid;
	lsuPkg::dataWord_t   ldData;
	logic                ldForwarded;
	logic                ldViolate;
	logic                ldStall;

	logic [31:0] lfsr = 32'he51a3de1;

	// scenario hit counts
	int hitFwd = 0;
	int hitVio = 0;
	int hitStall = 0;
	int hitFullDrop = 0;

	`include "lsuRefModel.svh"

	loadExecPath dut0 (
		.clk            (clk),
		.reset          (reset),
		.stAlloc_i      (stAlloc),
		.stExecValid_i  (stExecValid),
		.stExecIdx_i    (stExecIdx),
		.stExecAddr_i   (stExecAddr),
		.stExecData_i   (stExecData),
		.stExecSize_i   (stExecSize),
		.stCommit_i     (stCommit),
		.recover_i      (recover),
		.ldValid_i      (ldValid),
		.ldAddr_i       (ldAddr),
		.ldSize_i       (ldSize),
		.ldSign_i       (ldSign),
		.ldLastSt_i     (ldLastSt),
		.ldHasOlderSt_i (ldHasOlderSt),
		.ldPredVio_i    (ldPredVio),
		.stqFull_o      (stqFull),
		.ldDataValid_o  (ldDataValid),
		.ldData_o       (ldData),
		.ldForwarded_o  (ldForwarded),
		.ldViolate_o    (ldViolate),
		.ldStall_o      (ldStall)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois form with taps 32 22 2 1
	function automatic logic lfsrStep();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 32'h80200003;
		return outBit;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsrStep()};
		return v;
	endfunction

	function automatic lsuPkg::accessSize_t randSize();
		lsuPkg::accessSize_t s;
		s = lsuPkg::accessSize_t'(randBits(2));
		// unused code 3 folds onto a word
		return (s == 2'd3) ? lsuPkg::SIZE_WORD : s;
	endfunction

	// naturally aligned with half of them crowded into four words so accesses collide
	function automatic lsuPkg::byteAddr_t randAddr(input lsuPkg::accessSize_t size);
		lsuPkg::wordAddr_t           w;
		logic [lsuPkg::OFFSET_W-1:0] off;
		if (randBits(1) != 0)
			w = lsuPkg::wordAddr_t'(randBits(2));
		else
			w = lsuPkg::wordAddr_t'(randBits(6));
		off = lsuPkg::OFFSET_W'(randBits(2));
		off = off & lsuPkg::OFFSET_W'(~((1 << size) - 1));
		return {w, off};
	endfunction

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic compareData(input string name, input lsuPkg::dataWord_t got,
		input lsuPkg::dataWord_t exp);
		if (got !== exp)
			stopOnError($sformatf("** Error at %0t: %s = 0x%h, expected 0x%h",
				$time, name, got, exp));
	endtask

	task automatic verifyFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stopOnError($sformatf("** Error at %0t: %s = %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic compareOutputs();
		if (dut0.chk0.failCount != 0)
			stopOnError("a bound assertion failed on the last clock edge");
		verifyFlag("stqFull_o", stqFull, mCount == lsuPkg::STQ_DEPTH);
		verifyFlag("ldDataValid_o", ldDataValid, expValid);
		verifyFlag("ldStall_o", ldStall, expStall);
		verifyFlag("ldForwarded_o", ldForwarded, expFwd);
		verifyFlag("ldViolate_o", ldViolate, expVio);
		compareData("ldData_o", ldData, expData);
		hitFwd   += expFwd;
		hitVio   += expVio;
		hitStall += expStall;
	endtask

	// fill mode allocates often and commits rarely so the queue reaches full
	task automatic driveCycle(input logic fill);
		int k;
		recover  = (randBits(6) == 0);
		stAlloc  = fill ? (randBits(2) != 0) : (randBits(1) != 0);
		stCommit = (mCount > 0) && mKnown[mHead] &&
			(fill ? (randBits(3) == 0) : (randBits(1) != 0));
		// execute only allocated entries that have no address yet
		k           = int'(randBits(3));
		stExecIdx   = lsuPkg::stqIdx_t'((mHead + k) % lsuPkg::STQ_DEPTH);
		stExecValid = (k < mCount) && !mKnown[stExecIdx];
		stExecSize  = randSize();
		stExecAddr  = randAddr(stExecSize);
		stExecData  = randBits(32);
		ldValid     = (randBits(2) != 0);
		ldSize      = randSize();
		ldAddr      = randAddr(ldSize);
		ldSign      = (randBits(1) != 0);
		ldPredVio   = (randBits(1) != 0);
		if (mCount > 0)
		begin
			ldHasOlderSt = (randBits(2) != 0);
			k            = int'(randBits(3)) % mCount;
			ldLastSt     = lsuPkg::stqIdx_t'((mHead + k) % lsuPkg::STQ_DEPTH);
		end
		else
		begin
			// on an empty queue any claimed older store must be ignored
			ldHasOlderSt = (randBits(1) != 0);
			ldLastSt     = lsuPkg::stqIdx_t'(randBits(3));
		end
	endtask

	initial
	begin
		reset        = 1'b1;
		stAlloc      = 1'b0;
		stExecValid  = 1'b0;
		stExecIdx    = '0;
		stExecAddr   = '0;
		stExecData   = '0;
		stExecSize   = '0;
		stCommit     = 1'b0;
		recover      = 1'b0;
		ldValid      = 1'b0;
		ldAddr       = '0;
		ldSize       = '0;
		ldSign       = 1'b0;
		ldLastSt     = '0;
		ldHasOlderSt = 1'b0;
		ldPredVio    = 1'b0;
		resetModel();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int n = 0; n < NUM_OPS; n++)
		begin
			@(negedge clk);
			compareOutputs();
			driveCycle(((n / 256) % 2) == 0);
			if (stAlloc && !recover && mCount == lsuPkg::STQ_DEPTH)
				hitFullDrop++;
			predictLoad();
			applyStoreEdge();
		end
		@(negedge clk);
		compareOutputs();
		if (hitFwd == 0 || hitVio == 0 || hitStall == 0 || hitFullDrop == 0)
			stopOnError("random traffic never reached a forward, violation, stall or full queue");
		else
		begin
			$display("Result: PASSED");
			$finish;
		end
	end

	// covers reset, all operations and a margin
	initial
	begin
		#((NUM_OPS + 16 + 100) * 10);
		stopOnError("watchdog timeout, the run did not finish in time");
	end

endmodule

//--- sources.f
+incdir+tb
hdl/lsuPkg.sv
hdl/storeQueue.sv
hdl/dataMemory.sv
hdl/loadResultMerge.sv
hdl/loadExecPath.sv
tb/loadExecPath_chk.sv
tb/loadExecPath_tb.sv
